/* all.f */
+incdir+hdl
hdl/exec_pkg.sv
hdl/exec_decode.sv
hdl/exec_alu.sv
hdl/exec_muldiv.sv
hdl/exec_result.sv
hdl/exec_top.sv
bench/exec_props.sv
bench/exec_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= exec_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Regression passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* bench/exec_tb.sv */
`timescale 1ns/1ns
`include "exec_cfg.svh"

module exec_tb;
    import exec_pkg::*;

    localparam int n_alu    = 200;
    localparam int n_muldiv = 40;
    localparam int n_branch = 100;
    localparam int n_idle   = 60;
    localparam int test_cycles = 10 + 4 + n_alu + 3 * n_muldiv + n_branch + n_idle + 4 * 2;
    localparam int watchdog_cycles = test_cycles + 100;

    localparam logic [5:0] alu_fns [13] = '{fn_and, fn_or, fn_xor, fn_addu, fn_subu,
        fn_slt, fn_sltu, fn_sll, fn_srl, fn_sra, fn_sllv, fn_srlv, fn_srav};
    localparam logic [5:0] alu_opcs [6] = '{opc_addiu, opc_slti, opc_sltiu,
        opc_andi, opc_ori, opc_xori};
    localparam logic [5:0] md_fns [4] = '{fn_mult, fn_multu, fn_div, fn_divu};

    logic        clk = 1'b0;
    logic        reset;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] rs_value;
    logic [31:0] rt_value;
    logic [31:0] result;
    logic        zero;
    logic        branch_taken;
    logic        result_valid;

    logic [31:0] rng_state = 32'h2556;
    logic [31:0] model_hi;
    logic [31:0] model_lo;
    logic [31:0] exp_result;
    logic        exp_zero;
    logic        exp_taken;
    logic        exp_valid;
    logic        pending;
    string       test_name;
    int          checks;
    int          errors;
    int          total_errors;
    int          tests_passed;
    int          tests_failed;

    exec_top dut (
        .clk          (clk),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .rs_value     (rs_value),
        .rt_value     (rt_value),
        .result       (result),
        .zero         (zero),
        .branch_taken (branch_taken),
        .result_valid (result_valid)
    );

    bind exec_top exec_props props (
        .clk          (clk),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .result_valid (result_valid),
        .result       (result),
        .zero         (zero),
        .branch_taken (branch_taken)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [31:0] random_alu_word();
        logic [31:0] r;
        int          k;
        r = next_rand();
        k = int'(next_rand() % 19);
        if (k < 13)
            return {opc_special, r[25:6], alu_fns[k]};
        return {alu_opcs[k - 13], r[25:0]};
    endfunction

    // Zero, negative, small or anything
    function automatic logic [31:0] biased_operand();
        logic [31:0] r;
        r = next_rand();
        case (r[1:0])
            2'd0:    return 32'h0;
            2'd1:    return next_rand() | 32'h8000_0000;
            2'd2:    return next_rand() & 32'h0000_0003;
            default: return next_rand();
        endcase
    endfunction

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: expected %08h, actual %08h", name, expected, actual);
        end
    endtask

    // MIPS semantics; HI and LO of the model change on mult and div
    task automatic predict(input logic [31:0] iw, input logic [31:0] rs,
                           input logic [31:0] rt, output logic [31:0] y,
                           output logic taken);
        logic [4:0]  sa;
        logic [31:0] se;
        logic [31:0] ze;
        logic [63:0] p;
        longint      q;
        longint      m;
        sa = iw[10:6];
        se = {{16{iw[15]}}, iw[15:0]};
        ze = {16'h0, iw[15:0]};
        y = rs;
        taken = 1'b0;
        case (iw[31:26])
            opc_special: begin
                case (iw[5:0])
                    fn_and:  y = rs & rt;
                    fn_or:   y = rs | rt;
                    fn_xor:  y = rs ^ rt;
                    fn_addu: y = rs + rt;
                    fn_subu: y = rs - rt;
                    fn_slt:  y = {31'h0, $signed(rs) < $signed(rt)};
                    fn_sltu: y = {31'h0, rs < rt};
                    fn_sll:  y = rt << sa;
                    fn_srl:  y = rt >> sa;
                    fn_sra:  y = $signed(rt) >>> sa;
                    fn_sllv: y = rt << rs[4:0];
                    fn_srlv: y = rt >> rs[4:0];
                    fn_srav: y = $signed(rt) >>> rs[4:0];
                    fn_mfhi: y = model_hi;
                    fn_mflo: y = model_lo;
                    fn_mult: begin
                        y = 32'h0;
                        p = longint'($signed(rs)) * longint'($signed(rt));
                        {model_hi, model_lo} = p;
                    end
                    fn_multu: begin
                        y = 32'h0;
                        p = {32'h0, rs} * {32'h0, rt};
                        {model_hi, model_lo} = p;
                    end
                    fn_div: begin
                        y = 32'h0;
                        if (rt != 32'h0) begin
                            q = longint'($signed(rs)) / longint'($signed(rt));
                            m = longint'($signed(rs)) % longint'($signed(rt));
                            model_lo = q[31:0];
                            model_hi = m[31:0];
                        end
                    end
                    fn_divu: begin
                        y = 32'h0;
                        if (rt != 32'h0) begin
                            model_lo = rs / rt;
                            model_hi = rs % rt;
                        end
                    end
                    default: y = rs;
                endcase
            end
            opc_beq: begin
                taken = (rs == rt);
                y = rs - rt;
            end
            opc_bne:   taken = (rs != rt);
            opc_blez:  taken = ($signed(rs) <= 0);
            opc_bgtz:  taken = ($signed(rs) > 0);
            opc_regimm: begin
                if (iw[20:16] == rt_bltz)
                    taken = rs[31];
                else if (iw[20:16] == rt_bgez)
                    taken = !rs[31];
            end
            opc_addiu: y = rs + se;
            opc_slti:  y = {31'h0, $signed(rs) < $signed(se)};
            opc_sltiu: y = {31'h0, rs < se};
            opc_andi:  y = rs & ze;
            opc_ori:   y = rs | ze;
            opc_xori:  y = rs ^ ze;
            default:   y = rs;
        endcase
        if (iw[31:26] inside {opc_bne, opc_blez, opc_bgtz} ||
            (iw[31:26] == opc_regimm && iw[20:16] inside {rt_bltz, rt_bgez}))
            y = taken ? 32'h0 : 32'h1;
    endtask

    task automatic check_outputs();
        compare({test_name, " result_valid"}, {31'h0, exp_valid}, {31'h0, result_valid});
        compare({test_name, " result"}, exp_result, result);
        compare({test_name, " zero"}, {31'h0, exp_zero}, {31'h0, zero});
        compare({test_name, " branch_taken"}, {31'h0, exp_taken}, {31'h0, branch_taken});
    endtask

    // Checks the previous cycle, then drives the next one
    task automatic step(input logic valid, input logic [31:0] iw,
                        input logic [31:0] rs, input logic [31:0] rt);
        logic [31:0] y;
        logic        taken;
        @(negedge clk);
        if (pending)
            check_outputs();
        instr_valid = valid;
        instr       = iw;
        rs_value    = rs;
        rt_value    = rt;
        if (valid) begin
            predict(iw, rs, rt, y, taken);
            exp_result = y;
            exp_zero   = (y == 32'h0);
            exp_taken  = taken;
        end
        exp_valid = valid;    // Idle keeps the last result and flags
        pending   = 1'b1;
    endtask

    task automatic end_test();
        step(1'b0, 32'h0, 32'h0, 32'h0);
        @(negedge clk);
        check_outputs();
        pending = 1'b0;
        $display("test %s: %0d checks, %0d errors", test_name, checks, errors);
        if (errors == 0)
            tests_passed++;
        else
            tests_failed++;
        total_errors += errors;
        checks = 0;
        errors = 0;
    endtask

    initial begin : watchdog
        #(watchdog_cycles * 100);
        $display("Timeout: the tests did not finish within %0d cycles", watchdog_cycles);
        $display("Regression failed");
        $finish;
    end

    initial begin : main
        logic [31:0] rs;
        logic [31:0] rt;
        logic [31:0] r;
        logic [5:0]  opc;
        logic [4:0]  sel;
        reset = 1'b0;
        instr_valid = 1'b0;
        instr = 32'h0;
        rs_value = 32'h0;
        rt_value = 32'h0;
        model_hi = `EXEC_HILO_INIT;
        model_lo = `EXEC_HILO_INIT;
        exp_result = 32'h0;
        exp_zero = 1'b0;
        exp_taken = 1'b0;
        exp_valid = 1'b0;
        pending = 1'b0;
        checks = 0;
        errors = 0;
        total_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (10) @(negedge clk);
        reset = 1'b1;

        test_name = "reset_state";
        check_outputs();
        step(1'b1, {opc_special, 20'h0, fn_mfhi}, 32'h0, 32'h0);
        step(1'b1, {opc_special, 20'h0, fn_mflo}, 32'h0, 32'h0);
        end_test();

        test_name = "alu_ops";
        repeat (n_alu) begin
            rs = next_rand();
            rt = (next_rand() % 4 == 0) ? rs : next_rand();    // Equal operands now and then
            step(1'b1, random_alu_word(), rs, rt);
        end
        end_test();

        test_name = "mul_div";
        repeat (n_muldiv) begin
            r  = next_rand();
            rs = next_rand();
            rt = next_rand();
            if (r[4:2] == 3'd0)
                rt = 32'h0;
            else if (r[4:2] == 3'd1)
                rt = rt >> 24;
            step(1'b1, {opc_special, r[25:6], md_fns[r[1:0]]}, rs, rt);
            step(1'b1, {opc_special, 20'h0, fn_mfhi}, next_rand(), next_rand());
            step(1'b1, {opc_special, 20'h0, fn_mflo}, next_rand(), next_rand());
        end
        end_test();

        test_name = "branches";
        repeat (n_branch) begin
            r   = next_rand();
            rs  = biased_operand();
            rt  = r[31] ? rs : biased_operand();
            sel = 5'h0;
            case (r[2:0])
                3'd0: begin
                    opc = opc_beq;
                    sel = r[20:16];
                end
                3'd1: begin
                    opc = opc_bne;
                    sel = r[20:16];
                end
                3'd2: opc = opc_blez;
                3'd3: opc = opc_bgtz;
                3'd4: begin
                    opc = opc_regimm;
                    sel = rt_bltz;
                end
                3'd5: begin
                    opc = opc_regimm;
                    sel = rt_bgez;
                end
                default: opc = opc_special;
            endcase
            if (opc == opc_special)
                step(1'b1, {opc_special, r[25:6], fn_subu}, rs, rs);    // Zero, not a branch
            else
                step(1'b1, {opc, r[25:21], sel, r[15:0]}, rs, rt);
        end
        end_test();

        test_name = "idle_gaps";
        repeat (n_idle) begin
            step(next_rand() % 3 != 0, random_alu_word(), next_rand(), next_rand());
        end
        end_test();

        $display("tests passed %0d, tests failed %0d, assertion failures %0d",
                 tests_passed, tests_failed, dut.props.violations);
        if (total_errors == 0 && dut.props.violations == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* bench/exec_props.sv */
`timescale 1ns/1ns
`include "exec_cfg.svh"

module exec_props (
    input logic                  clk,
    input logic                  reset,
    input logic                  instr_valid,
    input logic                  result_valid,
    input logic [`EXEC_XLEN-1:0] result,
    input logic                  zero,
    input logic                  branch_taken
);

    int violations = 0;    // Read by the testbench at the end of the run

    valid_follows: assert property (@(posedge clk) disable iff (!reset)
        $past(reset) |-> (result_valid == $past(instr_valid)))
        else begin
            violations++;
            $error("result_valid did not follow instr_valid by one cycle");
        end

    // A taken branch carries an all-zero ALU word
    taken_needs_zero: assert property (@(posedge clk)
        branch_taken |-> (zero && result == '0))
        else begin
            violations++;
            $error("branch_taken high while zero is low or result is nonzero");
        end

    // First edge out of reset still shows the reset values
    quiet_after_reset: assert property (@(posedge clk)
        $rose(reset) |-> (!result_valid && !branch_taken))
        else begin
            violations++;
            $error("outputs not cleared by reset");
        end

endmodule

/* hdl/exec_top.sv */
`timescale 1ns/1ns
`include "exec_cfg.svh"

module exec_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   instr_valid,
    input  logic [`EXEC_XLEN-1:0]  instr,
    input  logic [`EXEC_XLEN-1:0]  rs_value,
    input  logic [`EXEC_XLEN-1:0]  rt_value,
    output logic [`EXEC_XLEN-1:0]  result,
    output logic                   zero,
    output logic                   branch_taken,
    output logic                   result_valid
);
    import exec_pkg::*;

    alu_op_t                  op;
    logic [`EXEC_XLEN-1:0]    op_a;
    logic [`EXEC_XLEN-1:0]    op_b;
    logic [`EXEC_SHAMT_W-1:0] shamt;
    logic                     is_branch;
    logic                     hilo_we;
    logic [`EXEC_XLEN-1:0]    hi;
    logic [`EXEC_XLEN-1:0]    lo;
    logic [`EXEC_XLEN-1:0]    alu_y;

    exec_decode u_decode (
        .instr       (instr),       // Raw word viewed through the union
        .instr_valid (instr_valid),
        .rs_value    (rs_value),
        .rt_value    (rt_value),
        .op          (op),
        .op_a        (op_a),
        .op_b        (op_b),
        .shamt       (shamt),
        .is_branch   (is_branch),
        .hilo_we     (hilo_we)
    );

    exec_alu u_alu (
        .op    (op),
        .a     (op_a),
        .b     (op_b),
        .shamt (shamt),
        .hi    (hi),
        .lo    (lo),
        .y     (alu_y)
    );

    exec_muldiv u_muldiv (
        .clk     (clk),
        .reset   (reset),
        .op      (op),
        .a       (op_a),
        .b       (op_b),
        .hilo_we (hilo_we),
        .hi      (hi),
        .lo      (lo)
    );

    exec_result u_result (
        .clk          (clk),
        .reset        (reset),
        .valid_in     (instr_valid),
        .y_in         (alu_y),
        .is_branch    (is_branch),
        .result       (result),
        .zero         (zero),
        .branch_taken (branch_taken),
        .result_valid (result_valid)
    );

endmodule

/* hdl/exec_result.sv */
`timescale 1ns/1ns
`include "exec_cfg.svh"

module exec_result (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   valid_in,
    input  logic [`EXEC_XLEN-1:0]  y_in,
    input  logic                   is_branch,
    output logic [`EXEC_XLEN-1:0]  result,
    output logic                   zero,
    output logic                   branch_taken,
    output logic                   result_valid
);

    logic branch_q;    // Registered along with the result

    always_ff @(posedge clk) begin
        if (!reset) begin
            result       <= '0;
            zero         <= 1'b0;
            branch_q     <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= valid_in;    // Drops on idle cycles
            if (valid_in) begin
                result   <= y_in;
                zero     <= (y_in == '0);
                branch_q <= is_branch;
            end
        end
    end

    // A branch word is zero exactly when the branch is taken
    assign branch_taken = branch_q & zero;

endmodule

/* hdl/exec_muldiv.sv */
`timescale 1ns/1ns
`include "exec_cfg.svh"

module exec_muldiv (
    input  logic                   clk,
    input  logic                   reset,
    input  exec_pkg::alu_op_t      op,
    input  logic [`EXEC_XLEN-1:0]  a,
    input  logic [`EXEC_XLEN-1:0]  b,
    input  logic                   hilo_we,
    output logic [`EXEC_XLEN-1:0]  hi,
    output logic [`EXEC_XLEN-1:0]  lo
);
    import exec_pkg::*;

    logic signed [2*`EXEC_XLEN-1:0] prod_s;
    logic        [2*`EXEC_XLEN-1:0] prod_u;
    logic        [`EXEC_XLEN-1:0]   divisor;
    logic                           div_ok;
    logic signed [`EXEC_XLEN-1:0]   quot_s;
    logic signed [`EXEC_XLEN-1:0]   rem_s;
    logic        [`EXEC_XLEN-1:0]   quot_u;
    logic        [`EXEC_XLEN-1:0]   rem_u;

    assign prod_s = $signed(a) * $signed(b);    // Operands sign extended to 64
    assign prod_u = a * b;

    // Divisor of zero is swapped for one so the dividers stay defined
    assign div_ok  = (b != '0);
    assign divisor = div_ok ? b : {{(`EXEC_XLEN-1){1'b0}}, 1'b1};

    // Truncation toward zero, remainder follows the dividend
    assign quot_s = $signed(a) / $signed(divisor);
    assign rem_s  = $signed(a) % $signed(divisor);
    assign quot_u = a / divisor;
    assign rem_u  = a % divisor;

    always_ff @(posedge clk) begin
        if (!reset) begin
            hi <= `EXEC_HILO_INIT;
            lo <= `EXEC_HILO_INIT;
        end else if (hilo_we) begin
            case (op)
                alu_mult:  {hi, lo} <= prod_s;
                alu_multu: {hi, lo} <= prod_u;
                alu_div: begin
                    if (div_ok) begin
                        hi <= rem_s;
                        lo <= quot_s;
                    end
                end
                alu_divu: begin
                    if (div_ok) begin
                        hi <= rem_u;
                        lo <= quot_u;
                    end
                end
                default: ;    // Other codes leave HI and LO alone
            endcase
        end
    end

endmodule

/* hdl/exec_alu.sv */
`timescale 1ns/1ns
`include "exec_cfg.svh"

module exec_alu (
    input  exec_pkg::alu_op_t         op,
    input  logic [`EXEC_XLEN-1:0]     a,
    input  logic [`EXEC_XLEN-1:0]     b,
    input  logic [`EXEC_SHAMT_W-1:0]  shamt,
    input  logic [`EXEC_XLEN-1:0]     hi,
    input  logic [`EXEC_XLEN-1:0]     lo,
    output logic [`EXEC_XLEN-1:0]     y
);
    import exec_pkg::*;

    logic [`EXEC_SHAMT_W-1:0] var_sh;
    logic                     a_neg;
    logic                     a_zero;

    // One bit result widened to a full word
    function automatic logic [`EXEC_XLEN-1:0] flag_word(input logic flag);
        flag_word = {{(`EXEC_XLEN-1){1'b0}}, flag};
    endfunction

    assign var_sh = a[`EXEC_SHAMT_W-1:0];    // Only low bits of rs count
    assign a_neg  = a[`EXEC_XLEN-1];
    assign a_zero = (a == '0);

    always_comb begin
        case (op)
            alu_and:  y = a & b;
            alu_or:   y = a | b;
            alu_xor:  y = a ^ b;
            alu_addu: y = a + b;
            alu_subu: y = a - b;
            alu_sltu: y = flag_word(a < b);
            alu_slt:  y = flag_word($signed(a) < $signed(b));

            // Fixed shifts act on rt by the shamt field
            alu_sll:  y = b << shamt;
            alu_srl:  y = b >> shamt;
            alu_sra:  y = $unsigned($signed(b) >>> shamt);
            alu_sllv: y = b << var_sh;
            alu_srlv: y = b >> var_sh;
            alu_srav: y = $unsigned($signed(b) >>> var_sh);

            alu_mfhi: y = hi;
            alu_mflo: y = lo;

            // Branch results are 0 when the condition holds
            alu_bltz: y = flag_word(!a_neg);
            alu_bgez: y = flag_word(a_neg);
            alu_bgtz: y = flag_word(a_neg || a_zero);
            alu_blez: y = flag_word(!(a_neg || a_zero));
            alu_bne:  y = flag_word(a == b);

            alu_pass_a: y = a;

            // Results of these land in HI and LO instead
            alu_mult,
            alu_multu,
            alu_div,
            alu_divu: y = '0;

            default:  y = '0;
        endcase
    end

endmodule

/* hdl/exec_decode.sv */
`timescale 1ns/1ns
`include "exec_cfg.svh"

module exec_decode (
    input  exec_pkg::instr_u          instr,
    input  logic                      instr_valid,
    input  logic [`EXEC_XLEN-1:0]     rs_value,
    input  logic [`EXEC_XLEN-1:0]     rt_value,
    output exec_pkg::alu_op_t         op,
    output logic [`EXEC_XLEN-1:0]     op_a,
    output logic [`EXEC_XLEN-1:0]     op_b,
    output logic [`EXEC_SHAMT_W-1:0]  shamt,
    output logic                      is_branch,
    output logic                      hilo_we
);
    import exec_pkg::*;

    logic [`EXEC_XLEN-1:0] imm_sext;
    logic [`EXEC_XLEN-1:0] imm_zext;

    assign imm_sext = {{(`EXEC_XLEN-16){instr.i.imm[15]}}, instr.i.imm};
    assign imm_zext = {{(`EXEC_XLEN-16){1'b0}}, instr.i.imm};

    assign op_a  = rs_value;
    assign shamt = instr.r.shamt;

    always_comb begin
        op        = alu_pass_a;
        op_b      = rt_value;     // R-type, beq and bne
        is_branch = 1'b0;
        case (instr.r.opcode)
            opc_special: begin
                case (instr.r.funct)
                    fn_and:   op = alu_and;
                    fn_or:    op = alu_or;
                    fn_xor:   op = alu_xor;
                    fn_addu:  op = alu_addu;
                    fn_subu:  op = alu_subu;
                    fn_slt:   op = alu_slt;
                    fn_sltu:  op = alu_sltu;
                    fn_sll:   op = alu_sll;
                    fn_srl:   op = alu_srl;
                    fn_sra:   op = alu_sra;
                    fn_sllv:  op = alu_sllv;
                    fn_srlv:  op = alu_srlv;
                    fn_srav:  op = alu_srav;
                    fn_mult:  op = alu_mult;
                    fn_multu: op = alu_multu;
                    fn_div:   op = alu_div;
                    fn_divu:  op = alu_divu;
                    fn_mfhi:  op = alu_mfhi;
                    fn_mflo:  op = alu_mflo;
                    fn_jr:    op = alu_pass_a;    // Target is just rs
                    default:  op = alu_pass_a;
                endcase
            end
            opc_regimm: begin
                if (instr.i.rt == rt_bltz) begin
                    op        = alu_bltz;
                    is_branch = 1'b1;
                end else if (instr.i.rt == rt_bgez) begin
                    op        = alu_bgez;
                    is_branch = 1'b1;
                end
            end
            opc_beq: begin
                op        = alu_subu;    // Zero result means equal
                is_branch = 1'b1;
            end
            opc_bne: begin
                op        = alu_bne;
                is_branch = 1'b1;
            end
            opc_blez: begin
                op        = alu_blez;
                is_branch = 1'b1;
            end
            opc_bgtz: begin
                op        = alu_bgtz;
                is_branch = 1'b1;
            end
            opc_addiu: begin
                op   = alu_addu;
                op_b = imm_sext;
            end
            opc_slti: begin
                op   = alu_slt;
                op_b = imm_sext;
            end
            opc_sltiu: begin
                op   = alu_sltu;
                op_b = imm_sext;    // Sign extended, compared unsigned
            end
            opc_andi: begin
                op   = alu_and;
                op_b = imm_zext;
            end
            opc_ori: begin
                op   = alu_or;
                op_b = imm_zext;
            end
            opc_xori: begin
                op   = alu_xor;
                op_b = imm_zext;
            end
            default: op = alu_pass_a;
        endcase
    end

    assign hilo_we = instr_valid &&
                     (op inside {alu_mult, alu_multu, alu_div, alu_divu});

endmodule

/* hdl/exec_pkg.sv */
`include "exec_cfg.svh"

package exec_pkg;

    typedef enum logic [4:0] {
        alu_and   = 5'd0,
        alu_or    = 5'd1,
        alu_xor   = 5'd2,
        alu_addu  = 5'd3,
        alu_subu  = 5'd4,     // Also beq, zero when equal
        alu_sltu  = 5'd5,
        alu_slt   = 5'd6,
        alu_multu = 5'd7,
        alu_mult  = 5'd8,
        alu_sll   = 5'd9,
        alu_sllv  = 5'd10,
        alu_sra   = 5'd11,
        alu_srl   = 5'd12,
        alu_srav  = 5'd13,
        alu_srlv  = 5'd14,
        alu_div   = 5'd15,
        alu_divu  = 5'd16,
        alu_mfhi  = 5'd17,
        alu_mflo  = 5'd18,
        alu_bltz  = 5'd19,    // Branch codes give 0 when taken
        alu_bgtz  = 5'd20,
        alu_bgez  = 5'd21,
        alu_bne   = 5'd22,
        alu_blez  = 5'd23,
        alu_pass_a = 5'd24    // jr and anything not decoded
    } alu_op_t;

    typedef struct packed {
        logic [5:0]               opcode;
        logic [4:0]               rs;
        logic [4:0]               rt;
        logic [4:0]               rd;
        logic [`EXEC_SHAMT_W-1:0] shamt;
        logic [5:0]               funct;
    } instr_r_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } instr_i_t;

    // One instruction word, field view picked by opcode
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    localparam logic [5:0] opc_special = 6'h00;
    localparam logic [5:0] opc_regimm  = 6'h01;
    localparam logic [5:0] opc_beq     = 6'h04;
    localparam logic [5:0] opc_bne     = 6'h05;
    localparam logic [5:0] opc_blez    = 6'h06;
    localparam logic [5:0] opc_bgtz    = 6'h07;
    localparam logic [5:0] opc_addiu   = 6'h09;
    localparam logic [5:0] opc_slti    = 6'h0a;
    localparam logic [5:0] opc_sltiu   = 6'h0b;
    localparam logic [5:0] opc_andi    = 6'h0c;
    localparam logic [5:0] opc_ori     = 6'h0d;
    localparam logic [5:0] opc_xori    = 6'h0e;

    localparam logic [5:0] fn_sll   = 6'h00;
    localparam logic [5:0] fn_srl   = 6'h02;
    localparam logic [5:0] fn_sra   = 6'h03;
    localparam logic [5:0] fn_sllv  = 6'h04;
    localparam logic [5:0] fn_srlv  = 6'h06;
    localparam logic [5:0] fn_srav  = 6'h07;
    localparam logic [5:0] fn_jr    = 6'h08;
    localparam logic [5:0] fn_mfhi  = 6'h10;
    localparam logic [5:0] fn_mflo  = 6'h12;
    localparam logic [5:0] fn_mult  = 6'h18;
    localparam logic [5:0] fn_multu = 6'h19;
    localparam logic [5:0] fn_div   = 6'h1a;
    localparam logic [5:0] fn_divu  = 6'h1b;
    localparam logic [5:0] fn_addu  = 6'h21;
    localparam logic [5:0] fn_subu  = 6'h23;
    localparam logic [5:0] fn_and   = 6'h24;
    localparam logic [5:0] fn_or    = 6'h25;
    localparam logic [5:0] fn_xor   = 6'h26;
    localparam logic [5:0] fn_slt   = 6'h2a;
    localparam logic [5:0] fn_sltu  = 6'h2b;

    localparam logic [4:0] rt_bltz = 5'h00;    // REGIMM selector in rt
    localparam logic [4:0] rt_bgez = 5'h01;

endpackage

/* hdl/exec_cfg.svh */
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// Data path width, fixed by the ISA
`define EXEC_XLEN 32

// Shift amount field and variable shift width
`define EXEC_SHAMT_W 5

// Value of HI and LO out of reset
`define EXEC_HILO_INIT 32'h0000_0000

`endif
